// ==== execUnit.f ====
+incdir+hdl
hdl/cr16Pkg.sv
hdl/regFile.sv
hdl/condCheck.sv
hdl/alu.sv
hdl/aluController.sv
hdl/execUnit.sv
tb/tbClockGen.sv
tb/execUnitTb.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execUnitTb
FILELIST  ?= execUnit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# output goes to the console and is searched for the pass message
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/execUnitTb.sv ====
`timescale 1ns/1ps
`include "cr16_defines.svh"

module execUnitTb;
	import cr16Pkg::*;

	logic        clk;
	logic        rstN;
	logic        req;
	logic [15:0] instr;
	logic        ack;
	logic [15:0] result;
	logic [4:0]  psr;

	// bookkeeping
	int errors;
	int checks;
	int testErrors;
	int testsRun;

	// reference model state
	logic [15:0] modelRegs [16];
	logic [4:0]  modelPsr;
	logic [31:0] lfsrState;

	// response captured while ack is high
	logic [15:0] gotResult;
	logic [4:0]  gotPsr;

	tbClockGen clockGen0 (
		.clk  (clk),
		.rstN (rstN)
	);

	execUnit i_dut (
		.clk    (clk),
		.rstN   (rstN),
		.req    (req),
		.instr  (instr),
		.ack    (ack),
		.result (result),
		.psr    (psr)
	);

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic nextBit();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	// n random bits right aligned
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], nextBit()};
		end
		return v;
	endfunction

	// packs the opcode with bits 11:8 and bits 7:0
	function automatic logic [15:0] encode(input opcodeT op, input logic [3:0] rd,
		input logic [7:0] low);
		return {op, rd, low};
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// add group writes C and F only
	function automatic logic [15:0] addModel(input logic [15:0] a, input logic [15:0] b,
		input logic cin);
		logic [16:0] u;
		int          sFull;
		u = {1'b0, a} + {1'b0, b} + {16'd0, cin};
		sFull = int'($signed(a)) + int'($signed(b)) + int'(cin);
		modelPsr[`PSR_C] = u[16];
		modelPsr[`PSR_F] = (sFull > 32767) || (sFull < -32768);
		return u[15:0];
	endfunction

	// subtract group writes all five flags
	function automatic logic [15:0] subModel(input logic [15:0] a, input logic [15:0] b,
		input logic bin);
		logic [16:0] need;
		int          sFull;
		need = {1'b0, b} + {16'd0, bin};
		sFull = int'($signed(a)) - int'($signed(b)) - int'(bin);
		modelPsr[`PSR_C] = ({1'b0, a} < need);
		modelPsr[`PSR_F] = (sFull > 32767) || (sFull < -32768);
		modelPsr[`PSR_L] = (a < b);
		modelPsr[`PSR_Z] = (a == b);
		modelPsr[`PSR_N] = ($signed(a) < $signed(b));
		return sFull[15:0];
	endfunction

	// positive amount goes left, negative goes right
	function automatic logic [15:0] shiftModel(input logic [15:0] val, input int amt,
		input logic arith);
		logic [15:0] r;
		if (amt >= 0) begin
			r = val << amt;
		end else if (arith) begin
			r = $signed(val) >>> (-amt);
		end else begin
			r = val >> (-amt);
		end
		return r;
	endfunction

	// condition table
	function automatic logic condModel(input logic [3:0] code, input logic [4:0] p);
		logic taken;
		case (condT'(code))
			COND_EQ: taken = p[`PSR_Z];
			COND_NE: taken = !p[`PSR_Z];
			COND_CS: taken = p[`PSR_C];
			COND_CC: taken = !p[`PSR_C];
			COND_HI: taken = p[`PSR_L];
			COND_LS: taken = !p[`PSR_L];
			COND_GT: taken = p[`PSR_N];
			COND_LE: taken = !p[`PSR_N];
			COND_FS: taken = p[`PSR_F];
			COND_FC: taken = !p[`PSR_F];
			COND_LO: taken = !p[`PSR_L] && !p[`PSR_Z];
			COND_HS: taken = p[`PSR_L] || p[`PSR_Z];
			COND_LT: taken = !p[`PSR_N] && !p[`PSR_Z];
			COND_GE: taken = p[`PSR_N] || p[`PSR_Z];
			COND_UC: taken = 1'b1;
			default: taken = 1'b0;
		endcase
		return taken;
	endfunction

	// runs one instruction on the model and returns the expected result
	task automatic modelExecute(input logic [15:0] word, output logic [15:0] res);
		opcodeT      op;
		logic [3:0]  rd;
		logic [3:0]  ex;
		logic [15:0] d;
		logic [15:0] s;
		logic [15:0] immS;
		logic [15:0] immZ;
		logic        wr;
		op = opcodeT'(word[15:12]);
		rd = word[11:8];
		ex = word[7:4];
		d = modelRegs[rd];
		s = modelRegs[word[3:0]];
		immS = {{8{word[7]}}, word[7:0]};
		immZ = {8'd0, word[7:0]};
		res = s;
		wr = 1'b1;
		case (op)
			OP_RTYPE: begin
				case (ex)
					4'd1: res = d & s;
					4'd2: res = d | s;
					4'd3: res = d ^ s;
					4'd5: res = addModel(d, s, 1'b0);
					4'd7: res = addModel(d, s, modelPsr[`PSR_C]);
					4'd9: res = subModel(d, s, 1'b0);
					4'd10: res = subModel(d, s, modelPsr[`PSR_C]);
					4'd11: begin
						res = subModel(d, s, 1'b0);
						wr = 1'b0;
					end
					4'd13: res = s;
					4'd14: res = d * s;
					default: wr = 1'b0;
				endcase
			end
			OP_ANDI: res = d & immZ;
			OP_ORI: res = d | immZ;
			OP_XORI: res = d ^ immZ;
			OP_ADDI: res = addModel(d, immS, 1'b0);
			OP_SUBI: res = subModel(d, immS, 1'b0);
			OP_CMPI: begin
				res = subModel(d, immS, 1'b0);
				wr = 1'b0;
			end
			OP_MULI: res = d * immS;
			OP_MOVI: res = immS;
			OP_LUI: res = {d[7:0], word[7:0]};
			OP_SHIFT: begin
				// immediate amount is bit 4 joined with bits 3:0
				case (ex)
					4'd0, 4'd1: res = shiftModel(d, int'($signed(word[4:0])), 1'b0);
					4'd2, 4'd3: res = shiftModel(d, int'($signed(word[4:0])), 1'b1);
					4'd4: res = shiftModel(d, int'($signed(s)), 1'b0);
					4'd6: res = shiftModel(d, int'($signed(s)), 1'b1);
					default: wr = 1'b0;
				endcase
			end
			OP_SPECIAL: begin
				if (ex == 4'b1101) begin
					res = {15'd0, condModel(word[3:0], modelPsr)};
				end else begin
					wr = 1'b0;
				end
			end
			default: wr = 1'b0;
		endcase
		if (wr) begin
			modelRegs[rd] = res;
		end
	endtask

	////////////////////////////////////////////////////////////
	// checking and handshake
	////////////////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [15:0] gotVal,
		input logic [15:0] expVal);
		checks++;
		assert (gotVal === expVal) else begin
			$display("CHECK FAILED at %0t: %s got 0x%04h expected 0x%04h",
				$time, name, gotVal, expVal);
			errors++;
			testErrors++;
		end
	endtask

	task automatic abortRun(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("Test failed");
		$finish;
	endtask

	// counts falling edges until ack reaches level within 50
	task automatic waitAck(input logic level, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (ack !== level && cycles < 50);
		if (ack !== level) begin
			abortRun($sformatf("ack did not reach %0b within 50 cycles", level));
		end
	endtask

	// full four-phase transfer of one instruction
	task automatic doInstr(input logic [15:0] word);
		int cycles;
		@(posedge clk);
		instr <= word;
		req <= 1'b1;
		waitAck(1'b1, cycles);
		gotResult = result;
		gotPsr = psr;
		@(posedge clk);
		req <= 1'b0;
		waitAck(1'b0, cycles);
	endtask

	task automatic execCheck(input logic [15:0] word);
		logic [15:0] expRes;
		modelExecute(word, expRes);
		doInstr(word);
		checkValue($sformatf("result of %04h", word), gotResult, expRes);
		checkValue($sformatf("psr after %04h", word), {11'd0, gotPsr}, {11'd0, modelPsr});
	endtask

	// movi puts the high byte in place, lui shifts it up and adds the low byte
	task automatic loadWord(input logic [3:0] rd, input logic [15:0] value);
		execCheck(encode(OP_MOVI, rd, value[15:8]));
		execCheck(encode(OP_LUI, rd, value[7:0]));
	endtask

	// mov rd, rd shows the register on result
	task automatic readBack(input logic [3:0] rd);
		execCheck(encode(OP_RTYPE, rd, {4'd13, rd}));
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (testErrors == 0) begin
			$display("%-24s ok", name);
		end else begin
			$display("%-24s %0d errors", name, testErrors);
		end
		testErrors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic testResetHandshake();
		int          cycles;
		logic [15:0] word;
		logic [15:0] expRes;
		checkValue("ack", {15'd0, ack}, 16'd0);
		checkValue("result", result, 16'd0);
		checkValue("psr", {11'd0, psr}, 16'd0);
		word = encode(OP_MOVI, 4'd0, 8'h5A);
		modelExecute(word, expRes);
		@(posedge clk);
		instr <= word;
		req <= 1'b1;
		// sampled one edge later, ack on the edge after that
		waitAck(1'b1, cycles);
		checkValue("ack latency", cycles[15:0], 16'd3);
		checkValue("result", result, expRes);
		// outputs hold under host back-pressure
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			checkValue("ack held", {15'd0, ack}, 16'd1);
			checkValue("result held", result, expRes);
		end
		@(posedge clk);
		req <= 1'b0;
		waitAck(1'b0, cycles);
		checkValue("ack release", cycles[15:0], 16'd2);
	endtask

	task automatic testMoves();
		logic [15:0] rv;
		for (int r = 0; r < 16; r++) begin
			rv = randBits(8);
			execCheck(encode(OP_MOVI, 4'(r), rv[7:0]));
		end
		// mirror copy where the upper half reads back already copied values
		for (int r = 0; r < 16; r++) begin
			execCheck(encode(OP_RTYPE, 4'(r), {4'd13, 4'(15 - r)}));
		end
		for (int r = 0; r < 16; r++) begin
			readBack(4'(r));
		end
	endtask

	task automatic testArith();
		logic [15:0] edges [4];
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] sel;
		logic [15:0] word;
		edges = '{16'h7FFF, 16'h8000, 16'hFFFF, 16'h0001};
		// add and sub over every edge pair
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				loadWord(4'd1, edges[i]);
				loadWord(4'd2, edges[j]);
				execCheck(encode(OP_RTYPE, 4'd1, 8'h52));
				loadWord(4'd1, edges[i]);
				execCheck(encode(OP_RTYPE, 4'd1, 8'h92));
			end
		end
		// ffff + 1 wraps with carry, addc then adds it in
		loadWord(4'd3, 16'hFFFF);
		loadWord(4'd4, 16'h0001);
		execCheck(encode(OP_RTYPE, 4'd3, 8'h54));
		checkValue("psr C after add", {15'd0, gotPsr[`PSR_C]}, 16'd1);
		loadWord(4'd5, 16'h1234);
		loadWord(4'd6, 16'h0010);
		execCheck(encode(OP_RTYPE, 4'd5, 8'h76));
		checkValue("addc sum", gotResult, 16'h1245);
		// 0 - 1 borrows, subc takes the borrow off as well
		loadWord(4'd7, 16'h0000);
		execCheck(encode(OP_RTYPE, 4'd7, 8'h94));
		loadWord(4'd8, 16'h0100);
		execCheck(encode(OP_RTYPE, 4'd8, 8'hA4));
		checkValue("subc difference", gotResult, 16'h00FE);
		// signed overflow through the immediate forms
		loadWord(4'd1, 16'h7FFF);
		execCheck(encode(OP_ADDI, 4'd1, 8'h01));
		checkValue("psr F after addi", {15'd0, gotPsr[`PSR_F]}, 16'd1);
		loadWord(4'd2, 16'h8000);
		execCheck(encode(OP_SUBI, 4'd2, 8'h01));
		checkValue("psr F after subi", {15'd0, gotPsr[`PSR_F]}, 16'd1);
		for (int i = 0; i < 16; i++) begin
			a = randBits(16);
			b = randBits(16);
			sel = randBits(3);
			loadWord(4'd9, a);
			loadWord(4'd10, b);
			case (sel[2:0])
				3'd0: word = encode(OP_RTYPE, 4'd9, 8'h5A);
				3'd2: word = encode(OP_RTYPE, 4'd9, 8'h9A);
				3'd3: word = encode(OP_RTYPE, 4'd9, 8'hAA);
				3'd4: word = encode(OP_ADDI, 4'd9, b[7:0]);
				3'd5: word = encode(OP_SUBI, 4'd9, b[7:0]);
				default: word = encode(OP_RTYPE, 4'd9, 8'h7A);
			endcase
			execCheck(word);
		end
	endtask

	task automatic testLogic();
		logic [15:0] rv;
		// 0x10 vs 0x20 leaves C, L and N set
		loadWord(4'd1, 16'h0010);
		loadWord(4'd2, 16'h0020);
		execCheck(encode(OP_RTYPE, 4'd1, 8'hB2));
		loadWord(4'd1, randBits(16));
		loadWord(4'd2, randBits(16));
		execCheck(encode(OP_RTYPE, 4'd1, 8'h12));
		execCheck(encode(OP_RTYPE, 4'd2, 8'h21));
		execCheck(encode(OP_RTYPE, 4'd1, 8'h32));
		execCheck(encode(OP_RTYPE, 4'd2, 8'hE1));
		rv = randBits(8);
		execCheck(encode(OP_MULI, 4'd1, rv[7:0] | 8'h80));
		// top bit set in each immediate so zero extension shows
		loadWord(4'd3, 16'hFFFF);
		execCheck(encode(OP_ANDI, 4'd3, 8'hF0));
		checkValue("andi zero extend", gotResult, 16'h00F0);
		loadWord(4'd3, 16'h0000);
		execCheck(encode(OP_ORI, 4'd3, 8'h80));
		checkValue("ori zero extend", gotResult, 16'h0080);
		rv = randBits(8);
		execCheck(encode(OP_XORI, 4'd2, rv[7:0] | 8'h80));
		rv = randBits(8);
		execCheck(encode(OP_LUI, 4'd2, rv[7:0]));
		checkValue("psr held", {11'd0, gotPsr}, 16'h0013);
	endtask

	task automatic testShifts();
		int          amts [6];
		logic [15:0] data [2];
		logic [4:0]  a5;
		logic [15:0] amt16;
		logic [15:0] word;
		amts = '{1, -1, 5, -5, 15, -15};
		data = '{16'h8421, 16'h1234};
		for (int i = 0; i < 6; i++) begin
			a5 = amts[i][4:0];
			amt16 = amts[i][15:0];
			for (int k = 0; k < 2; k++) begin
				loadWord(4'd2, amt16);
				// lshi, ashui, lsh, ashu on fresh data each time
				for (int form = 0; form < 4; form++) begin
					loadWord(4'd1, data[k]);
					case (form)
						0: word = encode(OP_SHIFT, 4'd1, {3'b000, a5});
						1: word = encode(OP_SHIFT, 4'd1, {3'b001, a5});
						2: word = encode(OP_SHIFT, 4'd1, {4'd4, 4'd2});
						default: word = encode(OP_SHIFT, 4'd1, {4'd6, 4'd2});
					endcase
					execCheck(word);
				end
			end
		end
		// right by four with sign fill
		loadWord(4'd1, 16'h8421);
		execCheck(encode(OP_SHIFT, 4'd1, {3'b001, 5'b11100}));
		checkValue("ashui sign fill", gotResult, 16'hF842);
	endtask

	task automatic testCompareScond();
		logic [15:0] dsts [4];
		logic [15:0] srcs [4];
		logic [15:0] expPsr [4];
		dsts = '{16'h1234, 16'h0010, 16'h8000, 16'hFFFF};
		srcs = '{16'h1234, 16'h0020, 16'h0001, 16'h0001};
		// N F Z L C from the compare rules
		expPsr = '{16'h0008, 16'h0013, 16'h0014, 16'h0010};
		for (int p = 0; p < 4; p++) begin
			loadWord(4'd1, dsts[p]);
			loadWord(4'd2, srcs[p]);
			execCheck(encode(OP_RTYPE, 4'd1, 8'hB2));
			checkValue("psr after cmp", {11'd0, gotPsr}, expPsr[p]);
			readBack(4'd1);
			checkValue("cmp destination", gotResult, dsts[p]);
			for (int c = 0; c < 16; c++) begin
				execCheck(encode(OP_SPECIAL, 4'd5, {4'b1101, 4'(c)}));
			end
		end
		// cmpi against a sign-extended immediate
		loadWord(4'd1, randBits(16));
		execCheck(encode(OP_CMPI, 4'd1, 8'h80));
		readBack(4'd1);
		for (int c = 0; c < 16; c++) begin
			execCheck(encode(OP_SPECIAL, 4'd6, {4'b1101, 4'(c)}));
		end
	endtask

	////////////////////////////////////////////////////////////
	// run
	////////////////////////////////////////////////////////////

	initial begin
		int cycles;
		req = 1'b0;
		instr = '0;
		errors = 0;
		checks = 0;
		testErrors = 0;
		testsRun = 0;
		lfsrState = 32'd67898;
		modelPsr = '0;
		for (int r = 0; r < 16; r++) begin
			modelRegs[r] = '0;
		end
		cycles = 0;
		while (rstN !== 1'b1 && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (rstN !== 1'b1) begin
			abortRun("reset was never released");
		end
		testResetHandshake();
		finishTest("reset and handshake");
		testMoves();
		finishTest("moves and registers");
		testArith();
		finishTest("arithmetic and flags");
		testLogic();
		finishTest("logic, multiply, lui");
		testShifts();
		finishTest("shifts");
		testCompareScond();
		finishTest("compare and scond");
		$display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tb/tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen (
	output logic clk,
	output logic rstN
);

	// 100 ns period, toggles every 50 ns
	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// reset low for eight rising edges
	// release lands on a falling edge, clear of the flop edge
	initial begin
		rstN = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

// ==== hdl/execUnit.sv ====
`timescale 1ns/1ps
`include "cr16_defines.svh"

module execUnit (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   req,
	input  logic [`DATA_WIDTH-1:0] instr,
	output logic                   ack,
	output logic [`DATA_WIDTH-1:0] result,
	output logic [4:0]             psr
);
	import cr16Pkg::*;

	execStateT state;

	// instruction fields
	opcodeT     opcode;
	logic [3:0] dstAddr;
	logic [3:0] ext;
	logic [3:0] srcAddr;
	logic [7:0] imm8;
	condT       condBits;

	// datapath
	logic [`DATA_WIDTH-1:0] dstData;
	logic [`DATA_WIDTH-1:0] srcData;
	logic [`DATA_WIDTH-1:0] immExt;
	logic [`DATA_WIDTH-1:0] srcOperand;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic [4:0]             aluFlags;
	logic                   wrEn;

	// decode outputs
	aluOpT aluOp;
	logic  useImm;
	logic  zeroExt;
	logic  useCarry;
	logic  regWrite;
	logic  flagWriteArith;
	logic  flagWriteCmp;

	////////////////////////////////////////////////////////////
	// field extraction and operand select
	////////////////////////////////////////////////////////////

	assign opcode = opcodeT'(instr[15:12]);
	// for scond this is still the destination field
	assign dstAddr = instr[11:8];
	assign ext = instr[7:4];
	assign srcAddr = instr[3:0];
	assign condBits = condT'(instr[3:0]);
	assign imm8 = instr[7:0];

	always_comb begin
		if (opcode == OP_SHIFT) begin
			// shift immediates are a signed 5-bit amount in bits 4:0
			immExt = {{(`DATA_WIDTH-5){instr[4]}}, instr[4:0]};
		end else if (zeroExt) begin
			immExt = {{(`DATA_WIDTH-8){1'b0}}, imm8};
		end else begin
			immExt = {{(`DATA_WIDTH-8){imm8[7]}}, imm8};
		end
	end

	assign srcOperand = useImm ? immExt : srcData;

	// register file only written in the exec cycle
	assign wrEn = (state == EXEC) && regWrite;

	regFile regFile0 (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (dstAddr),
		.rdAddrB (srcAddr),
		.wrEn    (wrEn),
		.wrAddr  (dstAddr),
		.wrData  (aluResult),
		.rdDataA (dstData),
		.rdDataB (srcData)
	);

	aluController aluController0 (
		.opcode         (opcode),
		.ext            (ext),
		.aluOp          (aluOp),
		.useImm         (useImm),
		.zeroExt        (zeroExt),
		.useCarry       (useCarry),
		.regWrite       (regWrite),
		.flagWriteArith (flagWriteArith),
		.flagWriteCmp   (flagWriteCmp)
	);

	alu alu0 (
		.dst      (dstData),
		.src      (srcOperand),
		.aluOp    (aluOp),
		.useCarry (useCarry),
		.psrIn    (psr),
		.condBits (condBits),
		.result   (aluResult),
		.flags    (aluFlags)
	);

	////////////////////////////////////////////////////////////
	// handshake fsm, result and psr registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
			ack <= 1'b0;
			result <= '0;
			psr <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						state <= EXEC;
					end
				end
				EXEC: begin
					// write back happens in this same edge through wrEn
					state <= DONE;
					ack <= 1'b1;
					result <= aluResult;
					if (flagWriteCmp) begin
						psr <= aluFlags;
					end else if (flagWriteArith) begin
						// add group updates carry and overflow only
						psr[`PSR_C] <= aluFlags[`PSR_C];
						psr[`PSR_F] <= aluFlags[`PSR_F];
					end
				end
				DONE: begin
					// hold ack, result and psr until the host drops req
					if (!req) begin
						state <= IDLE;
						ack <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/aluController.sv ====
`timescale 1ns/1ps
`include "cr16_defines.svh"

module aluController (
	input  cr16Pkg::opcodeT opcode,
	input  logic [3:0]      ext,
	output cr16Pkg::aluOpT  aluOp,
	output logic            useImm,
	output logic            zeroExt,
	output logic            useCarry,
	output logic            regWrite,
	output logic            flagWriteArith,
	output logic            flagWriteCmp
);
	import cr16Pkg::*;

	always_comb begin
		// unknown encodings fall through as a mov that writes nothing
		aluOp = ALU_MOV;
		useImm = 1'b0;
		zeroExt = 1'b0;
		useCarry = 1'b0;
		regWrite = 1'b0;
		flagWriteArith = 1'b0;
		flagWriteCmp = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				// register/register group, op picked by ext
				regWrite = 1'b1;
				case (ext)
					4'd1: aluOp = ALU_AND;
					4'd2: aluOp = ALU_OR;
					4'd3: aluOp = ALU_XOR;
					4'd5: begin
						aluOp = ALU_ADD;
						flagWriteArith = 1'b1;
					end
					4'd7: begin
						// addc
						aluOp = ALU_ADD;
						useCarry = 1'b1;
						flagWriteArith = 1'b1;
					end
					4'd9: begin
						aluOp = ALU_SUB;
						flagWriteCmp = 1'b1;
					end
					4'd10: begin
						// subc
						aluOp = ALU_SUB;
						useCarry = 1'b1;
						flagWriteCmp = 1'b1;
					end
					4'd11: begin
						// cmp only touches the psr
						aluOp = ALU_SUB;
						regWrite = 1'b0;
						flagWriteCmp = 1'b1;
					end
					4'd13: aluOp = ALU_MOV;
					4'd14: aluOp = ALU_MUL;
					default: regWrite = 1'b0;
				endcase
			end
			// logic immediates are zero extended
			OP_ANDI, OP_ORI, OP_XORI: begin
				aluOp = (opcode == OP_ANDI) ? ALU_AND : (opcode == OP_ORI) ? ALU_OR : ALU_XOR;
				useImm = 1'b1;
				zeroExt = 1'b1;
				regWrite = 1'b1;
			end
			OP_ADDI: begin
				aluOp = ALU_ADD;
				useImm = 1'b1;
				regWrite = 1'b1;
				flagWriteArith = 1'b1;
			end
			OP_SUBI, OP_CMPI: begin
				aluOp = ALU_SUB;
				useImm = 1'b1;
				regWrite = (opcode == OP_SUBI);
				flagWriteCmp = 1'b1;
			end
			OP_MULI: begin
				aluOp = ALU_MUL;
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			OP_MOVI: begin
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			OP_LUI: begin
				aluOp = ALU_LUI;
				useImm = 1'b1;
				zeroExt = 1'b1;
				regWrite = 1'b1;
			end
			OP_SPECIAL: begin
				// only scond is defined in this group
				if (ext == 4'b1101) begin
					aluOp = ALU_SCOND;
					regWrite = 1'b1;
				end
			end
			OP_SHIFT: begin
				regWrite = 1'b1;
				// ext 0..3 carry amount bit 4, ext 4/6 take the amount from a register
				case (ext)
					4'd0, 4'd1: begin
						aluOp = ALU_LSH;
						useImm = 1'b1;
					end
					4'd2, 4'd3: begin
						aluOp = ALU_ASH;
						useImm = 1'b1;
					end
					4'd4: aluOp = ALU_LSH;
					4'd6: aluOp = ALU_ASH;
					default: regWrite = 1'b0;
				endcase
			end
			default: aluOp = ALU_MOV;
		endcase
	end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`include "cr16_defines.svh"

module alu (
	input  logic [`DATA_WIDTH-1:0] dst,
	input  logic [`DATA_WIDTH-1:0] src,
	input  cr16Pkg::aluOpT         aluOp,
	input  logic                   useCarry,
	input  logic [4:0]             psrIn,
	input  cr16Pkg::condT          condBits,
	output logic [`DATA_WIDTH-1:0] result,
	output logic [4:0]             flags
);
	import cr16Pkg::*;

	logic                   isSub;
	logic [`DATA_WIDTH-1:0] addB;
	logic                   carryIn;
	logic [`DATA_WIDTH:0]   sumFull;
	logic [`DATA_WIDTH-1:0] sum;
	logic                   carryOut;
	logic                   overflow;
	logic [`DATA_WIDTH-1:0] negAmt;
	logic [`DATA_WIDTH-1:0] shLeft;
	logic [`DATA_WIDTH-1:0] lshRight;
	logic [`DATA_WIDTH-1:0] ashRight;
	logic                   condTaken;

	////////////////////////////////////////////////////////////
	// shared adder
	////////////////////////////////////////////////////////////

	// subtract is dst + ~src + 1, borrow in drops the +1
	assign isSub = (aluOp == ALU_SUB);
	assign addB = isSub ? ~src : src;

	always_comb begin
		if (isSub) begin
			carryIn = useCarry ? ~psrIn[`PSR_C] : 1'b1;
		end else begin
			carryIn = useCarry & psrIn[`PSR_C];
		end
	end

	assign sumFull = {1'b0, dst} + {1'b0, addB} + {{`DATA_WIDTH{1'b0}}, carryIn};
	assign sum = sumFull[`DATA_WIDTH-1:0];
	assign carryOut = sumFull[`DATA_WIDTH];
	// operands agree in sign but the sum does not
	assign overflow = (dst[`DATA_WIDTH-1] == addB[`DATA_WIDTH-1]) &&
		(sum[`DATA_WIDTH-1] != dst[`DATA_WIDTH-1]);

	always_comb begin
		flags = 5'd0;
		// borrow is the inverted carry out on subtract
		flags[`PSR_C] = isSub ? ~carryOut : carryOut;
		flags[`PSR_F] = overflow;
		flags[`PSR_L] = (dst < src);
		flags[`PSR_Z] = (dst == src);
		flags[`PSR_N] = ($signed(dst) < $signed(src));
	end

	////////////////////////////////////////////////////////////
	// shifter
	////////////////////////////////////////////////////////////

	// src is a signed amount, negative shifts right by its magnitude
	assign negAmt = -src;
	assign shLeft = dst << src;
	assign lshRight = dst >> negAmt;
	// sign fill on the arithmetic right shift
	assign ashRight = $signed(dst) >>> negAmt;

	// scond test against the current psr
	condCheck condCheck0 (
		.cond  (condBits),
		.psr   (psrIn),
		.taken (condTaken)
	);

	////////////////////////////////////////////////////////////
	// result select
	////////////////////////////////////////////////////////////

	always_comb begin
		case (aluOp)
			ALU_ADD, ALU_SUB: result = sum;
			// low half of the product only
			ALU_MUL: result = dst * src;
			ALU_AND: result = dst & src;
			ALU_OR: result = dst | src;
			ALU_XOR: result = dst ^ src;
			ALU_SCOND: result = {{(`DATA_WIDTH-1){1'b0}}, condTaken};
			ALU_LUI: result = (dst << 8) | src;
			ALU_LSH: result = src[`DATA_WIDTH-1] ? lshRight : shLeft;
			ALU_ASH: result = src[`DATA_WIDTH-1] ? ashRight : shLeft;
			// mov and anything undecoded pass src through
			default: result = src;
		endcase
	end

endmodule

// ==== hdl/condCheck.sv ====
`timescale 1ns/1ps
`include "cr16_defines.svh"

module condCheck (
	input  cr16Pkg::condT cond,
	input  logic [4:0]    psr,
	output logic          taken
);
	import cr16Pkg::*;

	// individual flags
	logic c;
	logic l;
	logic f;
	logic z;
	logic n;

	assign c = psr[`PSR_C];
	assign l = psr[`PSR_L];
	assign f = psr[`PSR_F];
	assign z = psr[`PSR_Z];
	assign n = psr[`PSR_N];

	always_comb begin
		case (cond)
			COND_EQ: taken = z;
			COND_NE: taken = ~z;
			COND_CS: taken = c;
			COND_CC: taken = ~c;
			COND_HI: taken = l;
			COND_LS: taken = ~l;
			COND_GT: taken = n;
			COND_LE: taken = ~n;
			COND_FS: taken = f;
			COND_FC: taken = ~f;
			// compound tests combine a lower flag with equal
			COND_LO: taken = ~(l | z);
			COND_HS: taken = l | z;
			COND_LT: taken = ~(n | z);
			COND_GE: taken = n | z;
			COND_UC: taken = 1'b1;
			// nv, never true
			default: taken = 1'b0;
		endcase
	end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "cr16_defines.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [3:0]             rdAddrA,
	input  logic [3:0]             rdAddrB,
	input  logic                   wrEn,
	input  logic [3:0]             wrAddr,
	input  logic [`DATA_WIDTH-1:0] wrData,
	output logic [`DATA_WIDTH-1:0] rdDataA,
	output logic [`DATA_WIDTH-1:0] rdDataB
);

	// general purpose registers r0..r15
	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// single write port, all registers cleared on reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// read ports are combinational
	// a write in this cycle shows up after the edge
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

// ==== hdl/cr16Pkg.sv ====
package cr16Pkg;

	// major opcode, instr[15:12]
	typedef enum logic [3:0] {
		OP_RTYPE   = 4'b0000,
		OP_ANDI    = 4'b0001,
		OP_ORI     = 4'b0010,
		OP_XORI    = 4'b0011,
		// scond lives here, ext 1101
		OP_SPECIAL = 4'b0100,
		OP_ADDI    = 4'b0101,
		OP_SHIFT   = 4'b1000,
		OP_SUBI    = 4'b1001,
		OP_CMPI    = 4'b1011,
		OP_MOVI    = 4'b1101,
		// multiply immediate uses the spare code
		OP_MULI    = 4'b1110,
		OP_LUI     = 4'b1111
	} opcodeT;

	// operation selected inside the alu
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_MUL,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SCOND,
		ALU_MOV,
		ALU_LUI,
		ALU_LSH,
		ALU_ASH
	} aluOpT;

	// condition codes for scond, tested against the psr
	typedef enum logic [3:0] {
		COND_EQ, COND_NE, COND_CS, COND_CC,
		COND_HI, COND_LS, COND_GT, COND_LE,
		COND_FS, COND_FC, COND_LO, COND_HS,
		COND_LT, COND_GE, COND_UC, COND_NV
	} condT;

	// req/ack handshake states of the execute stage
	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		DONE
	} execStateT;

endpackage

// ==== hdl/cr16_defines.svh ====
`ifndef CR16_DEFINES_SVH
`define CR16_DEFINES_SVH

// datapath and register file sizing
`define DATA_WIDTH 16
`define REG_COUNT 16

// psr bit positions
// carry / borrow
`define PSR_C 0
// unsigned lower
`define PSR_L 1
// signed overflow
`define PSR_F 2
// equal
`define PSR_Z 3
// signed lower
`define PSR_N 4

`endif
